/* source/fetch_pkg.sv */
package fetch_pkg;

    ////////////////////
    // pointer and length
    ////////////////////

    // byte pointer into the instruction buffer
    localparam int BIP_BITS = 6;

    // decode reports 8 bits, only these move the pointer
    localparam int LEN_USED_BITS = 6;

    localparam int PACKET_BYTES = 16;

    // wraps modulo 64
    typedef logic [BIP_BITS-1:0] bip_t;

    typedef logic [7:0] len_t;

    ////////////////////
    // packet and control flow
    ////////////////////

    // byte 0 of the packet sits in bits 7:0
    typedef logic [PACKET_BYTES*8-1:0] packet_t;

    // higher encoding has priority
    typedef enum logic [1:0] {
        CF_NONE    = 2'd0,
        CF_BRANCH  = 2'd1,
        CF_RESTEER = 2'd2,
        CF_INIT    = 2'd3
    } cf_src_e;

endpackage

/* source/ibuf_pkg.sv */
package ibuf_pkg;

    // buffer geometry
    localparam int NUM_LINES  = 4;
    localparam int LINE_BYTES = 16;
    localparam int BUF_BYTES  = NUM_LINES * LINE_BYTES;

    // byte offset bits inside one line
    localparam int LINE_OFS_BITS = $clog2(LINE_BYTES);

    typedef logic [$clog2(NUM_LINES)-1:0] line_idx_t;

    typedef logic [LINE_BYTES*8-1:0] line_t;

    // one valid bit per line
    typedef logic [NUM_LINES-1:0] line_mask_t;

endpackage

/* source/instr_buffer.sv */
`timescale 1ns/1ps

module instr_buffer (
    input  logic                             clk,
    input  logic                             rst_n,

    ////////////////////
    // fill port
    ////////////////////
    input  logic                             fill_valid,
    input  ibuf_pkg::line_idx_t              fill_index,
    input  ibuf_pkg::line_t                  fill_data,

    ////////////////////
    // from the aligner
    ////////////////////
    input  logic                             release_line,
    input  ibuf_pkg::line_idx_t              release_index,
    input  logic                             flush,

    ////////////////////
    // to fetch
    ////////////////////
    output logic [ibuf_pkg::BUF_BYTES*8-1:0] window,
    output ibuf_pkg::line_mask_t             line_valid
);

    import ibuf_pkg::*;

    line_t lines [NUM_LINES];
    line_t fill_swapped;

    // memory side sends byte 0 in the top bits
    always_comb begin
        for (int b = 0; b < LINE_BYTES; b++) begin
            fill_swapped[8*b +: 8] = fill_data[8*(LINE_BYTES-1-b) +: 8];
        end
    end

    // stored lines keep byte 0 low
    always_ff @(posedge clk) begin
        if (fill_valid) begin
            lines[fill_index] <= fill_swapped;
        end
    end

    // fill wins over release and release over flush
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            line_valid <= '0;
        end else begin
            for (int i = 0; i < NUM_LINES; i++) begin
                if (fill_valid && fill_index == line_idx_t'(i)) begin
                    line_valid[i] <= 1'b1;
                end else if (release_line && release_index == line_idx_t'(i)) begin
                    line_valid[i] <= 1'b0;
                end else if (flush) begin
                    line_valid[i] <= 1'b0;
                end
            end
        end
    end

    // line 0 in the low bytes, so window byte k is buffer byte k
    for (genvar g = 0; g < NUM_LINES; g++) begin : g_window
        assign window[g*LINE_BYTES*8 +: LINE_BYTES*8] = lines[g];
    end

endmodule

/* source/byte_rotator.sv */
`timescale 1ns/1ps

module byte_rotator (
    input  logic [ibuf_pkg::BUF_BYTES*8-1:0] window,
    input  fetch_pkg::bip_t                  shift,
    output fetch_pkg::packet_t               rotated
);

    import fetch_pkg::*;
    import ibuf_pkg::*;

    logic [BUF_BYTES*8-1:0] stage1;
    logic [BUF_BYTES*8-1:0] stage2;
    logic [BUF_BYTES*8-1:0] stage4;
    logic [BUF_BYTES*8-1:0] stage8;
    logic [BUF_BYTES*8-1:0] stage16;
    logic [BUF_BYTES*8-1:0] stage32;

    // circular shift toward byte 0
    function automatic logic [BUF_BYTES*8-1:0] rot_down(
        input logic [BUF_BYTES*8-1:0] data,
        input int                     nbytes
    );
        logic [2*BUF_BYTES*8-1:0] twice;
        twice = {data, data};
        return twice[8*nbytes +: BUF_BYTES*8];
    endfunction

    ////////////////////
    // log shifter
    ////////////////////

    // one stage per pointer bit
    assign stage1  = shift[0] ? rot_down(window, 1)   : window;
    assign stage2  = shift[1] ? rot_down(stage1, 2)   : stage1;
    assign stage4  = shift[2] ? rot_down(stage2, 4)   : stage2;
    assign stage8  = shift[3] ? rot_down(stage4, 8)   : stage4;
    assign stage16 = shift[4] ? rot_down(stage8, 16)  : stage8;
    assign stage32 = shift[5] ? rot_down(stage16, 32) : stage16;

    // byte at the pointer lands in bits 7:0
    assign rotated = stage32[PACKET_BYTES*8-1:0];

endmodule

/* source/fetch_align.sv */
`timescale 1ns/1ps

module fetch_align (
    input  logic                 clk,
    input  logic                 rst_n,

    ////////////////////
    // decode
    ////////////////////
    input  fetch_pkg::len_t      decode_length,
    input  logic                 stall,

    ////////////////////
    // control flow
    ////////////////////
    input  fetch_pkg::bip_t      wb_target,
    input  logic                 resteer,
    input  fetch_pkg::bip_t      bp_target,
    input  logic                 branch_taken,
    input  fetch_pkg::bip_t      init_target,
    input  logic                 init,

    ////////////////////
    // buffer and rotator
    ////////////////////
    input  ibuf_pkg::line_mask_t line_valid,
    input  fetch_pkg::packet_t   fetched,

    // interrupt descriptor path
    input  fetch_pkg::packet_t   idt_packet,
    input  logic                 idt_select,
    input  logic                 ie_pending,

    output fetch_pkg::packet_t   packet,
    output logic                 packet_valid,
    output fetch_pkg::bip_t      old_bip,
    output fetch_pkg::bip_t      new_bip,
    output logic                 release_line,
    output ibuf_pkg::line_idx_t  release_index,
    output logic                 flush
);

    import fetch_pkg::*;
    import ibuf_pkg::*;

    cf_src_e   cf_src;
    logic      cf_event;
    bip_t      cf_target;
    line_idx_t old_line;
    line_idx_t cur_line;
    line_idx_t next_line;
    logic      window_valid;
    logic      advance;

    // sequential pointer
    assign new_bip = old_bip + bip_t'(decode_length[LEN_USED_BITS-1:0]);

    // init over resteer over branch
    always_comb begin
        if (init) begin
            cf_src = CF_INIT;
        end else if (resteer) begin
            cf_src = CF_RESTEER;
        end else if (branch_taken) begin
            cf_src = CF_BRANCH;
        end else begin
            cf_src = CF_NONE;
        end
    end

    always_comb begin
        case (cf_src)
            CF_INIT:    cf_target = init_target;
            CF_RESTEER: cf_target = wb_target;
            CF_BRANCH:  cf_target = bp_target;
            default:    cf_target = new_bip;
        endcase
    end

    assign cf_event = (cf_src != CF_NONE);

    // window spans the line of new_bip and the next one
    assign cur_line     = line_idx_t'(new_bip >> LINE_OFS_BITS);
    assign next_line    = cur_line + line_idx_t'(1);
    assign window_valid = line_valid[cur_line] & line_valid[next_line];

    // pending interrupt enable blocks normal fetch
    assign packet_valid = (window_valid & ~ie_pending) | idt_select;
    assign packet       = idt_select ? idt_packet : fetched;

    assign advance = ~stall & packet_valid;

    // line left behind by a forward step
    assign old_line      = line_idx_t'(old_bip >> LINE_OFS_BITS);
    assign release_line  = advance & ~cf_event & (old_line != cur_line);
    assign release_index = old_line;
    assign flush         = cf_event;

    // control flow loads even under stall
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            old_bip <= '0;
        end else if (cf_event) begin
            old_bip <= cf_target;
        end else if (advance) begin
            old_bip <= new_bip;
        end
    end

endmodule

/* source/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit (
    input  logic                 clk,
    input  logic                 rst_n,

    ////////////////////
    // memory side
    ////////////////////
    input  logic                 fill_valid,
    input  ibuf_pkg::line_idx_t  fill_index,
    input  ibuf_pkg::line_t      fill_data,

    // decode
    input  fetch_pkg::len_t      decode_length,
    input  logic                 stall,

    ////////////////////
    // control flow
    ////////////////////
    input  fetch_pkg::bip_t      wb_target,
    input  logic                 resteer,
    input  fetch_pkg::bip_t      bp_target,
    input  logic                 branch_taken,
    input  fetch_pkg::bip_t      init_target,
    input  logic                 init,

    input  fetch_pkg::packet_t   idt_packet,
    input  logic                 idt_select,
    input  logic                 ie_pending,

    output fetch_pkg::packet_t   packet,
    output logic                 packet_valid,
    output fetch_pkg::bip_t      old_bip,
    output fetch_pkg::bip_t      new_bip,
    output ibuf_pkg::line_mask_t line_valid
);

    import fetch_pkg::*;
    import ibuf_pkg::*;

    logic [BUF_BYTES*8-1:0] window;
    packet_t                fetched;
    logic                   release_line;
    line_idx_t              release_index;
    logic                   flush;

    instr_buffer instr_buffer_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .fill_valid    (fill_valid),
        .fill_index    (fill_index),
        .fill_data     (fill_data),
        .release_line  (release_line),
        .release_index (release_index),
        .flush         (flush),
        .window        (window),
        .line_valid    (line_valid)
    );

    // rotates at the sequential pointer
    byte_rotator byte_rotator_inst (
        .window  (window),
        .shift   (new_bip),
        .rotated (fetched)
    );

    fetch_align fetch_align_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .decode_length (decode_length),
        .stall         (stall),
        .wb_target     (wb_target),
        .resteer       (resteer),
        .bp_target     (bp_target),
        .branch_taken  (branch_taken),
        .init_target   (init_target),
        .init          (init),
        .line_valid    (line_valid),
        .fetched       (fetched),
        .idt_packet    (idt_packet),
        .idt_select    (idt_select),
        .ie_pending    (ie_pending),
        .packet        (packet),
        .packet_valid  (packet_valid),
        .old_bip       (old_bip),
        .new_bip       (new_bip),
        .release_line  (release_line),
        .release_index (release_index),
        .flush         (flush)
    );

endmodule

/* verification/fetch_model.svh */
// shadow copy of the buffer, byte k of the array is buffer byte k
logic [7:0] shadow_mem [BUF_BYTES];
line_mask_t shadow_valid;
bip_t       shadow_bip;

// only the low six length bits move the pointer, wrap at 64
function automatic bip_t next_bip(input bip_t bip, input len_t len);
    return bip_t'((int'(bip) + int'(len) % 64) % BUF_BYTES);
endfunction

function automatic packet_t expect_window(input bip_t bip);
    packet_t p;
    for (int k = 0; k < PACKET_BYTES; k++) begin
        p[8*k +: 8] = shadow_mem[(int'(bip) + k) % BUF_BYTES];
    end
    return p;
endfunction

function automatic logic expect_valid(input bip_t bip, input logic ie, input logic idt);
    int line;
    int nxt;
    line = int'(bip) / LINE_BYTES;
    nxt  = (line + 1) % NUM_LINES;
    return (shadow_valid[line] && shadow_valid[nxt] && !ie) || idt;
endfunction

// next state from the inputs that the coming rising edge samples
task automatic update_model();
    bip_t nb;
    bip_t target;
    logic pv;
    logic cf;
    logic adv;
    logic rel;
    int   old_line;
    if (!rst_n) begin
        shadow_valid = '0;
        shadow_bip   = '0;
    end else begin
        nb       = next_bip(shadow_bip, decode_length);
        pv       = expect_valid(nb, ie_pending, idt_select);
        cf       = init || resteer || branch_taken;
        target   = init ? init_target : (resteer ? wb_target : bp_target);
        adv      = !stall && pv;
        old_line = int'(shadow_bip) / LINE_BYTES;
        rel      = adv && !cf && (old_line != int'(nb) / LINE_BYTES);
        for (int i = 0; i < NUM_LINES; i++) begin
            if (fill_valid && int'(fill_index) == i) begin
                shadow_valid[i] = 1'b1;
            end else if ((rel && old_line == i) || cf) begin
                shadow_valid[i] = 1'b0;
            end
        end
        // memory side sends byte 0 in the top bits
        if (fill_valid) begin
            for (int b = 0; b < LINE_BYTES; b++) begin
                shadow_mem[int'(fill_index)*LINE_BYTES + b] =
                    fill_data[8*(LINE_BYTES-1-b) +: 8];
            end
        end
        if (cf) begin
            shadow_bip = target;
        end else if (adv) begin
            shadow_bip = nb;
        end
    end
endtask

/* verification/fetch_unit_tb.sv */
`timescale 1ns/1ps

module fetch_unit_tb;

    import fetch_pkg::*;
    import ibuf_pkg::*;

    localparam int RESET_CYCLES    = 5;
    localparam int RANDOM_STEPS    = 240;
    localparam int DIRECTED_CYCLES = 160;
    localparam int STIM_CYCLES     = RESET_CYCLES + RANDOM_STEPS + DIRECTED_CYCLES;
    localparam int TIMEOUT_CYCLES  = STIM_CYCLES + 200;

    logic       clk;
    logic       rst_n;
    logic       fill_valid;
    line_idx_t  fill_index;
    line_t      fill_data;
    len_t       decode_length;
    logic       stall;
    bip_t       wb_target;
    logic       resteer;
    bip_t       bp_target;
    logic       branch_taken;
    bip_t       init_target;
    logic       init;
    packet_t    idt_packet;
    logic       idt_select;
    logic       ie_pending;
    packet_t    packet;
    logic       packet_valid;
    bip_t       old_bip;
    bip_t       new_bip;
    line_mask_t line_valid;

    logic [31:0] rng_state;
    int          cycle_count;

    `include "fetch_model.svh"

    fetch_unit fetch_unit_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .fill_valid    (fill_valid),
        .fill_index    (fill_index),
        .fill_data     (fill_data),
        .decode_length (decode_length),
        .stall         (stall),
        .wb_target     (wb_target),
        .resteer       (resteer),
        .bp_target     (bp_target),
        .branch_taken  (branch_taken),
        .init_target   (init_target),
        .init          (init),
        .idt_packet    (idt_packet),
        .idt_select    (idt_select),
        .ie_pending    (ie_pending),
        .packet        (packet),
        .packet_valid  (packet_valid),
        .old_bip       (old_bip),
        .new_bip       (new_bip),
        .line_valid    (line_valid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////
    // random numbers
    ////////////////////

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic len_t rand_len();
        return len_t'(32'd1 + (lcg_next() >> 8) % 32'd15);
    endfunction

    function automatic bip_t rand_bip();
        return bip_t'(lcg_next() >> 20);
    endfunction

    function automatic line_t rand_line();
        line_t l;
        for (int w = 0; w < 4; w++) begin
            l[32*w +: 32] = lcg_next();
        end
        return l;
    endfunction

    ////////////////////
    // checks
    ////////////////////

    task automatic stop_on_failure();
        $display("tests failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_packet(input string what, input packet_t got, input packet_t exp);
        if (got !== exp) begin
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_bip(input string what, input bip_t got, input bip_t exp);
        if (got !== exp) begin
            $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_mask(input string what, input line_mask_t got, input line_mask_t exp);
        if (got !== exp) begin
            $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    // outputs are settled at the falling edge
    always @(negedge clk) begin
        bip_t exp_new;
        logic exp_valid;
        if (cycle_count > 0) begin
            exp_new   = next_bip(shadow_bip, decode_length);
            exp_valid = expect_valid(exp_new, ie_pending, idt_select);
            check_bip("old_bip", old_bip, shadow_bip);
            check_bip("new_bip", new_bip, exp_new);
            check_mask("line_valid", line_valid, shadow_valid);
            check_bit("packet_valid", packet_valid, exp_valid);
            if (idt_select) begin
                check_packet("idt packet", packet, idt_packet);
            end else if (exp_valid) begin
                check_packet("packet", packet, expect_window(exp_new));
            end
            update_model();
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("simulation did not finish within %0d cycles", TIMEOUT_CYCLES);
            stop_on_failure();
        end
    end

    ////////////////////
    // stimulus
    ////////////////////

    // later assignments in the same step override these defaults
    task automatic next_cycle();
        @(posedge clk);
        fill_valid    <= 1'b0;
        decode_length <= '0;
        stall         <= 1'b0;
        resteer       <= 1'b0;
        branch_taken  <= 1'b0;
        init          <= 1'b0;
        idt_select    <= 1'b0;
        ie_pending    <= 1'b0;
    endtask

    task automatic fill_line(input int idx);
        next_cycle();
        fill_valid <= 1'b1;
        fill_index <= line_idx_t'(idx);
        fill_data  <= rand_line();
    endtask

    task automatic fill_missing();
        for (int i = 0; i < NUM_LINES; i++) begin
            if (!shadow_valid[i]) begin
                fill_line(i);
            end
        end
        next_cycle();
    endtask

    task automatic control_flow(input logic do_init, input logic do_resteer,
                                input logic do_branch);
        next_cycle();
        decode_length <= rand_len();
        init          <= do_init;
        resteer       <= do_resteer;
        branch_taken  <= do_branch;
        init_target   <= rand_bip();
        wb_target     <= rand_bip();
        bp_target     <= rand_bip();
        // refill once the flush has taken effect
        next_cycle();
        fill_missing();
    endtask

    task automatic random_run(input int steps);
        int refill;
        for (int s = 0; s < steps; s++) begin
            refill = -1;
            for (int i = NUM_LINES - 1; i >= 0; i--) begin
                if (!shadow_valid[i]) begin
                    refill = i;
                end
            end
            next_cycle();
            decode_length <= rand_len();
            if (refill >= 0) begin
                fill_valid <= 1'b1;
                fill_index <= line_idx_t'(refill);
                fill_data  <= rand_line();
            end
        end
    endtask

    initial begin
        rng_state     = 32'h67e574dc;
        cycle_count   = 0;
        shadow_valid  = '0;
        shadow_bip    = '0;
        rst_n         = 1'b0;
        fill_valid    = 1'b0;
        fill_index    = '0;
        fill_data     = '0;
        decode_length = '0;
        stall         = 1'b0;
        wb_target     = '0;
        resteer       = 1'b0;
        bp_target     = '0;
        branch_taken  = 1'b0;
        init_target   = '0;
        init          = 1'b0;
        idt_packet    = '0;
        idt_select    = 1'b0;
        ie_pending    = 1'b0;

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        next_cycle();
        next_cycle();

        // full buffer, random lengths, released lines get refilled
        fill_missing();
        random_run(RANDOM_STEPS);

        // run into an empty line and hold there
        do begin
            next_cycle();
            decode_length <= 8'd15;
            @(negedge clk);
        end while (packet_valid);
        repeat (3) begin
            next_cycle();
            decode_length <= 8'd15;
        end
        fill_missing();
        repeat (2) begin
            next_cycle();
            decode_length <= 8'd9;
        end
        repeat (4) begin
            next_cycle();
            stall         <= 1'b1;
            decode_length <= 8'd7;
        end

        // control flow, alone and together
        control_flow(1'b1, 1'b0, 1'b0);
        control_flow(1'b0, 1'b1, 1'b0);
        control_flow(1'b0, 1'b0, 1'b1);
        control_flow(1'b1, 1'b1, 1'b1);
        control_flow(1'b0, 1'b1, 1'b1);
        control_flow(1'b1, 1'b0, 1'b1);

        // fill in the same cycle as a flush
        next_cycle();
        init       <= 1'b1;
        fill_valid <= 1'b1;
        fill_index <= line_idx_t'(2);
        fill_data  <= rand_line();
        next_cycle();
        fill_missing();

        // interrupt descriptor override and suppression
        next_cycle();
        idt_select <= 1'b1;
        idt_packet <= {rand_line()};
        decode_length <= rand_len();
        next_cycle();
        ie_pending    <= 1'b1;
        decode_length <= rand_len();
        next_cycle();
        ie_pending <= 1'b1;
        idt_select <= 1'b1;
        idt_packet <= {rand_line()};
        control_flow(1'b1, 1'b0, 1'b0);
        next_cycle();
        next_cycle();

        $display("all tests passed");
        $finish;
    end

endmodule

/* project.f */
+incdir+verification
source/fetch_pkg.sv
source/ibuf_pkg.sv
source/instr_buffer.sv
source/byte_rotator.sv
source/fetch_align.sv
source/fetch_unit.sv
verification/fetch_unit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f project.f --top-module fetch_unit_tb

output=$(./obj_dir/Vfetch_unit_tb)
echo "$output"

if ! grep -q "all tests passed" <<< "$output"; then
    exit 1
fi
